/* hw/zbus_glue.sv */
`timescale 1ns/1ps

module zbus_glue
	import zx_pkg::*;
(
	input  logic                fclk,
	input  logic                reset,
	input  zbus_t               zbus,
	output logic [7:0]          d_out,
	output logic                d_oe,
	output logic [PAGE_W-1:0]   page,
	output logic                csrom,
	output logic                dos_n,
	output logic [BORDER_W-1:0] border,
	output logic                beep,
	output logic [1:0]          turbo,
	output logic                int_n
);

	zstrobe_t  zstrobe;
	memconf_u  memconf;
	xt_pages_t xt_pages;
	logic      dos;

	////////////////////////////////////////////////////////////
	// strobes
	////////////////////////////////////////////////////////////

	zsignals u_zsignals (
		.fclk    (fclk),
		.reset   (reset),
		.zbus    (zbus),
		.zstrobe (zstrobe)
	);

	////////////////////////////////////////////////////////////
	// ports, paging, interrupt
	////////////////////////////////////////////////////////////

	zports u_zports (
		.fclk     (fclk),
		.reset    (reset),
		.zbus     (zbus),
		.zstrobe  (zstrobe),
		.dos      (dos),
		.memconf  (memconf),
		.xt_pages (xt_pages),
		.border   (border),
		.beep     (beep),
		.turbo    (turbo),
		.d_out    (d_out),
		.d_oe     (d_oe)
	);

	zpager u_zpager (
		.fclk     (fclk),
		.reset    (reset),
		.zbus     (zbus),
		.zstrobe  (zstrobe),
		.memconf  (memconf),
		.xt_pages (xt_pages),
		.page     (page),
		.csrom    (csrom),
		.dos      (dos),
		.dos_n    (dos_n)
	);

	// frame start comes from its own timer
	zint u_zint (
		.fclk    (fclk),
		.reset   (reset),
		.zstrobe (zstrobe),
		.int_n   (int_n)
	);

endmodule

/* hw/zint.sv */
`timescale 1ns/1ps

module zint
	import zx_pkg::*;
(
	input  logic     fclk,
	input  logic     reset,
	input  zstrobe_t zstrobe,
	output logic     int_n
);

	logic [$clog2(INT_PERIOD)-1:0] frame_cnt;
	logic [$clog2(INT_LEN)-1:0]    len_cnt;
	logic                          frame_wrap;
	logic                          int_act;

	assign frame_wrap = frame_cnt == ($clog2(INT_PERIOD))'(INT_PERIOD - 1);

	always_ff @(posedge fclk) begin
		if (reset) begin
			frame_cnt <= '0;
			len_cnt   <= '0;
			int_act   <= 1'b0;
		end else begin
			frame_cnt <= frame_wrap ? '0 : frame_cnt + 1'b1;
			if (frame_wrap) begin
				// new frame
				int_act <= 1'b1;
				len_cnt <= '0;
			end else if (int_act) begin
				len_cnt <= len_cnt + 1'b1;
				// acknowledge ends it early
				if (zstrobe.intack || len_cnt == ($clog2(INT_LEN))'(INT_LEN - 1))
					int_act <= 1'b0;
			end
		end
	end

	assign int_n = ~int_act;

endmodule

/* hw/zpager.sv */
`timescale 1ns/1ps

module zpager
	import zx_pkg::*;
(
	input  logic              fclk,
	input  logic              reset,
	input  zbus_t             zbus,
	input  zstrobe_t          zstrobe,
	input  memconf_u          memconf,
	input  xt_pages_t         xt_pages,
	output logic [PAGE_W-1:0] page,
	output logic              csrom,
	output logic              dos,
	output logic              dos_n
);

	logic [1:0] win;
	logic       dos_on;
	logic       dos_off;

	assign win = zbus.a[15:14];

	////////////////////////////////////////////////////////////
	// window to page
	////////////////////////////////////////////////////////////

	always_comb begin
		page  = xt_pages.page0;
		csrom = 1'b0;
		case (win)
			2'd0: begin
				if (!memconf.f.w0_ram) begin
					// dos selects rom 0 or 1, otherwise rom 2 or 3
					page  = {{(PAGE_W-2){1'b0}}, ~dos, memconf.f.rom128};
					csrom = 1'b1;
				end
			end
			2'd1:
				page = xt_pages.page1;
			2'd2:
				page = xt_pages.page2;
			default:
				page = xt_pages.page3;
		endcase
	end

	////////////////////////////////////////////////////////////
	// dos flag
	////////////////////////////////////////////////////////////

	// entry at 3Dxx of the 128 basic rom
	assign dos_on = zstrobe.opfetch_s && csrom && memconf.f.rom128
		&& zbus.a[15:8] == DOS_ENTRY_HI;

	// any fetch outside window 0 leaves dos
	assign dos_off = zstrobe.opfetch_s && win != 2'd0;

	always_ff @(posedge fclk) begin
		if (reset)
			dos <= 1'b0;
		else if (dos_on)
			dos <= 1'b1;
		else if (dos_off)
			dos <= 1'b0;
	end

	assign dos_n = ~dos;

endmodule

/* hw/zports.sv */
`timescale 1ns/1ps

module zports
	import zx_pkg::*;
(
	input  logic                fclk,
	input  logic                reset,
	input  zbus_t               zbus,
	input  zstrobe_t            zstrobe,
	input  logic                dos,
	output memconf_u            memconf,
	output xt_pages_t           xt_pages,
	output logic [BORDER_W-1:0] border,
	output logic                beep,
	output logic [1:0]          turbo,
	output logic [7:0]          d_out,
	output logic                d_oe
);

	logic [6:0] sysconf;
	logic [7:0] im2vect;
	logic [7:0] port_hi;
	logic       fe_hit;
	logic       af_hit;

	assign port_hi = zbus.a[15:8];
	assign fe_hit  = zbus.a[7:0] == PORT_FE;
	assign af_hit  = zbus.a[7:0] == PORT_AF_LO;

	assign turbo = sysconf[1:0];

	////////////////////////////////////////////////////////////
	// port writes
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk) begin
		if (reset) begin
			border      <= '0;
			beep        <= 1'b0;
			xt_pages    <= PAGES_RST;
			sysconf     <= SYSCONF_RST[6:0];
			memconf.raw <= MEMCONF_RST;
			im2vect     <= IM2VECT_RST;
		end else if (zstrobe.iowr_s) begin
			// ula port, low byte only
			if (fe_hit) begin
				border <= zbus.d_in[BORDER_W-1:0];
				beep   <= zbus.d_in[4];
			end
			if (af_hit) begin
				case (port_hi)
					AF_BORDER:
						border <= zbus.d_in[BORDER_W-1:0];
					AF_PAGE0:
						xt_pages.page0 <= zbus.d_in;
					AF_PAGE0 + 8'd1:
						xt_pages.page1 <= zbus.d_in;
					AF_PAGE0 + 8'd2:
						xt_pages.page2 <= zbus.d_in;
					AF_PAGE0 + 8'd3:
						xt_pages.page3 <= zbus.d_in;
					AF_SYSCONF:
						sysconf <= zbus.d_in[6:0];
					AF_MEMCONF:
						memconf.raw <= zbus.d_in;
					AF_IM2VECT:
						im2vect <= zbus.d_in;
					default: ;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////
	// readback
	////////////////////////////////////////////////////////////

	always_comb begin
		d_out = 8'h00;
		d_oe  = 1'b0;
		if (zstrobe.intack) begin
			// IM2 vector for the acknowledge cycle
			d_out = im2vect;
			d_oe  = 1'b1;
		end else if (zstrobe.iord && af_hit) begin
			d_oe = 1'b1;
			case (port_hi)
				AF_PAGE0:
					d_out = xt_pages.page0;
				AF_PAGE0 + 8'd1:
					d_out = xt_pages.page1;
				AF_PAGE0 + 8'd2:
					d_out = xt_pages.page2;
				AF_PAGE0 + 8'd3:
					d_out = xt_pages.page3;
				AF_SYSCONF:
					d_out = {dos, sysconf};
				AF_MEMCONF:
					d_out = memconf.raw;
				AF_IM2VECT:
					d_out = im2vect;
				// border too, it is write only
				default:
					d_oe = 1'b0;
			endcase
		end
	end

endmodule

/* hw/zsignals.sv */
`timescale 1ns/1ps

module zsignals
	import zx_pkg::*;
(
	input  logic     fclk,
	input  logic     reset,
	input  zbus_t    zbus,
	output zstrobe_t zstrobe
);

	localparam int SYNC_STAGES = 2;

	typedef struct packed {
		logic iorq;
		logic mreq;
		logic rd;
		logic wr;
		logic m1;
	} pins_t;

	pins_t pins;
	pins_t sync_q [SYNC_STAGES];
	pins_t s;
	logic  iowr;
	logic  opfetch;
	logic  iowr_seen;
	logic  opfetch_seen;
	logic  iowr_s_q;
	logic  opfetch_s_q;

	// active high copies of the pins
	assign pins = '{
		iorq: ~zbus.iorq_n,
		mreq: ~zbus.mreq_n,
		rd:   ~zbus.rd_n,
		wr:   ~zbus.wr_n,
		m1:   ~zbus.m1_n
	};

	always_ff @(posedge fclk) begin
		if (reset) begin
			for (int i = 0; i < SYNC_STAGES; i++)
				sync_q[i] <= '0;
		end else begin
			sync_q[0] <= pins;
			for (int i = 1; i < SYNC_STAGES; i++)
				sync_q[i] <= sync_q[i-1];
		end
	end

	assign s       = sync_q[SYNC_STAGES-1];
	assign iowr    = s.iorq & s.wr;
	assign opfetch = s.mreq & s.m1 & s.rd;

	// one pulse per bus cycle, however long the cycle
	always_ff @(posedge fclk) begin
		if (reset) begin
			iowr_seen    <= 1'b0;
			opfetch_seen <= 1'b0;
			iowr_s_q     <= 1'b0;
			opfetch_s_q  <= 1'b0;
		end else begin
			iowr_seen    <= iowr;
			opfetch_seen <= opfetch;
			iowr_s_q     <= iowr & ~iowr_seen;
			opfetch_s_q  <= opfetch & ~opfetch_seen;
		end
	end

	assign zstrobe = '{
		iord:      s.iorq & s.rd,
		mreq:      s.mreq,
		m1:        s.m1,
		rd:        s.rd,
		iowr_s:    iowr_s_q,
		opfetch_s: opfetch_s_q,
		intack:    s.m1 & s.iorq
	};

endmodule

/* hw/zx_pkg.sv */
package zx_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	localparam int PAGE_W   = 8;
	localparam int BORDER_W = 3;

	// port addresses
	localparam logic [7:0] PORT_FE    = 8'hFE;
	localparam logic [7:0] PORT_AF_LO = 8'hAF;
	localparam logic [7:0] AF_BORDER  = 8'h0F;
	localparam logic [7:0] AF_PAGE0   = 8'h10;
	localparam logic [7:0] AF_SYSCONF = 8'h20;
	localparam logic [7:0] AF_MEMCONF = 8'h21;
	localparam logic [7:0] AF_IM2VECT = 8'h24;

	// opcode fetch from this high byte in 128K ROM enters TR-DOS
	localparam logic [7:0] DOS_ENTRY_HI = 8'h3D;

	// frame timer, in fclk cycles
	localparam int INT_PERIOD = 512;
	localparam int INT_LEN    = 32;

	////////////////////////////////////////////////////////////
	// bus types
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic        iorq_n;
		logic        mreq_n;
		logic        rd_n;
		logic        wr_n;
		logic        m1_n;
		logic [15:0] a;
		logic [7:0]  d_in;
	} zbus_t;

	// levels and pulses, all in the fclk domain
	typedef struct packed {
		logic iord;
		logic mreq;
		logic m1;
		logic rd;
		logic iowr_s;
		logic opfetch_s;
		logic intack;
	} zstrobe_t;

	typedef struct packed {
		logic [5:0] unused;
		logic       w0_ram;
		logic       rom128;
	} memconf_t;

	typedef union packed {
		logic [7:0] raw;
		memconf_t   f;
	} memconf_u;

	// one page per 16K window, page0 in the low byte
	typedef struct packed {
		logic [PAGE_W-1:0] page3;
		logic [PAGE_W-1:0] page2;
		logic [PAGE_W-1:0] page1;
		logic [PAGE_W-1:0] page0;
	} xt_pages_t;

	// reset values
	localparam logic [7:0] MEMCONF_RST = 8'h00;
	localparam logic [7:0] SYSCONF_RST = 8'h00;
	localparam logic [7:0] IM2VECT_RST = 8'hFF;
	localparam xt_pages_t  PAGES_RST   = '{page3: 8'h00, page2: 8'h02, page1: 8'h05, page0: 8'h00};

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the zbus_glue testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
	--top-module tb_zbus_glue \
	-f zbus_glue.f \
	--Mdir obj_dir \
	-o sim_zbus_glue; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/sim_zbus_glue; then
	echo "simulation reported a failure"
	exit 1
fi

echo "simulation finished without errors"
exit 0

/* tests/tb_zbus_glue.sv */
`timescale 1ns/1ps

module tb_zbus_glue
	import zx_pkg::*;
();

	// one line of the golden file
	typedef struct packed {
		logic [7:0]  op;
		logic [15:0] a;
		logic [7:0]  d;
		logic [7:0]  e1;
		logic [7:0]  e2;
		logic [7:0]  e3;
	} step_t;

	logic                fclk;
	logic                reset;
	zbus_t               zbus;
	logic [7:0]          d_out;
	logic                d_oe;
	logic [PAGE_W-1:0]   page;
	logic                csrom;
	logic                dos_n;
	logic [BORDER_W-1:0] border;
	logic                beep;
	logic [1:0]          turbo;
	logic                int_n;

	step_t steps[$];
	bit    loaded;
	int    limit;

	// dut outputs caught in the middle of a bus cycle
	logic [7:0]        mid_d_out;
	logic              mid_d_oe;
	logic [PAGE_W-1:0] mid_page;
	logic              mid_csrom;

	zbus_glue u_zbus_glue (
		.fclk   (fclk),
		.reset  (reset),
		.zbus   (zbus),
		.d_out  (d_out),
		.d_oe   (d_oe),
		.page   (page),
		.csrom  (csrom),
		.dos_n  (dos_n),
		.border (border),
		.beep   (beep),
		.turbo  (turbo),
		.int_n  (int_n)
	);

	initial begin
		fclk = 1'b0;
		forever #20 fclk = ~fclk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	////////////////////////////////////////////////////////////
	// z80 bus cycles
	////////////////////////////////////////////////////////////

	// 6 cycles of strobes, then 2 idle
	task automatic bus_cycle(input zbus_t cyc);
		@(posedge fclk);
		#2 zbus = cyc;
		repeat (4) @(posedge fclk);
		@(negedge fclk);
		mid_d_out = d_out;
		mid_d_oe  = d_oe;
		mid_page  = page;
		mid_csrom = csrom;
		repeat (2) @(posedge fclk);
		#2 zbus = {5'b11111, 16'h0000, 8'h00};
		@(posedge fclk);
	endtask

	// strobe order: iorq_n mreq_n rd_n wr_n m1_n
	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		bus_cycle({5'b01101, a, d});
	endtask

	task automatic io_read(input logic [15:0] a);
		bus_cycle({5'b01011, a, 8'h00});
	endtask

	task automatic mem_read(input logic [15:0] a);
		bus_cycle({5'b10011, a, 8'h00});
	endtask

	task automatic opfetch(input logic [15:0] a);
		bus_cycle({5'b10010, a, 8'h00});
	endtask

	task automatic int_ack();
		bus_cycle({5'b01110, 16'h0000, 8'h00});
	endtask

	task automatic wait_int();
		int n;
		n = 0;
		@(negedge fclk);
		while (int_n !== 1'b0) begin
			if (n > INT_PERIOD)
				abort_run("int_n did not go low within one frame");
			@(negedge fclk);
			n++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// golden file
	////////////////////////////////////////////////////////////

	task automatic load_golden();
		int         fd;
		int         n;
		string      line;
		logic [7:0] op;
		logic [15:0] a;
		logic [7:0] d;
		logic [7:0] e1;
		logic [7:0] e2;
		logic [7:0] e3;
		fd = $fopen("tests/zbus_golden.txt", "r");
		if (fd == 0)
			abort_run("cannot open tests/zbus_golden.txt");
		while ($fgets(line, fd) > 0) begin
			// comments and blank lines
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%c %h %h %h %h %h", op, a, d, e1, e2, e3);
			if (n != 6)
				abort_run({"malformed line in golden file: ", line});
			steps.push_back({op, a, d, e1, e2, e3});
		end
		$fclose(fd);
	endtask

	task automatic apply_step(input step_t s);
		case (s.op)
			"W":
				io_write(s.a, s.d);
			"R": begin
				io_read(s.a);
				check("d_oe", 8'(mid_d_oe), 8'h01);
				check("d_out", mid_d_out, s.e1);
			end
			"M": begin
				mem_read(s.a);
				check("page", mid_page, s.e1);
				check("csrom", 8'(mid_csrom), s.e2);
			end
			"F": begin
				opfetch(s.a);
				@(negedge fclk);
				check("dos_n", 8'(dos_n), s.e1);
			end
			"P": begin
				@(negedge fclk);
				check("border", 8'(border), s.e1);
				check("beep", 8'(beep), s.e2);
				check("turbo", 8'(turbo), s.e3);
			end
			"I": begin
				wait_int();
				int_ack();
				check("d_oe", 8'(mid_d_oe), 8'h01);
				check("d_out", mid_d_out, s.e1);
				@(negedge fclk);
				check("int_n", 8'(int_n), 8'h01);
			end
			default:
				abort_run("unknown operation in golden file");
		endcase
	endtask

	initial begin
		reset = 1'b1;
		zbus  = {5'b11111, 16'h0000, 8'h00};
		load_golden();
		// room for every bus cycle plus a few frames of waiting for INT
		limit  = steps.size() * 8 + 4 * INT_PERIOD;
		loaded = 1'b1;
		repeat (5) @(posedge fclk);
		#2 reset = 1'b0;
		@(negedge fclk);
		check("d_oe", 8'(d_oe), 8'h00);
		check("int_n", 8'(int_n), 8'h01);
		check("dos_n", 8'(dos_n), 8'h01);
		foreach (steps[i])
			apply_step(steps[i]);
		$display("Test completed successfully");
		$finish;
	end

	// watchdog
	initial begin
		wait (loaded);
		repeat (limit) @(posedge fclk);
		abort_run("watchdog expired before all golden lines were run");
	end

endmodule

/* tests/zbus_glue_assert.sv */
`timescale 1ns/1ps

module zbus_glue_assert
	import zx_pkg::*;
(
	input logic     fclk,
	input logic     reset,
	input zstrobe_t zstrobe,
	input logic     d_oe,
	input logic     int_n
);

	logic [$clog2(INT_LEN)+1:0] low_cnt;

	// cycles int_n has been low so far
	always_ff @(posedge fclk) begin
		if (reset || int_n)
			low_cnt <= '0;
		else
			low_cnt <= low_cnt + 1'b1;
	end

	a_no_oe_on_write: assert property (@(posedge fclk) disable iff (reset)
		zstrobe.iowr_s |-> !d_oe)
		else $error("d_oe high during an I/O write");

	a_int_len: assert property (@(posedge fclk) disable iff (reset)
		low_cnt <= ($bits(low_cnt))'(INT_LEN))
		else $error("int_n low for more than INT_LEN cycles");

	a_oe_after_reset: assert property (@(posedge fclk) reset |=> !d_oe)
		else $error("d_oe high right after reset");

endmodule

bind zbus_glue zbus_glue_assert u_zbus_glue_assert (
	.fclk    (fclk),
	.reset   (reset),
	.zstrobe (zstrobe),
	.d_oe    (d_oe),
	.int_n   (int_n)
);

/* tests/zbus_golden.txt */
# op addr data e1 e2 e3, all hex; R e1=d_out, M e1=page e2=csrom, F e1=dos_n after fetch
# P e1=border e2=beep e3=turbo, I e1=IM2 vector; unused columns are 00
R 10AF 00 00 00 00
R 11AF 00 05 00 00
R 12AF 00 02 00 00
R 13AF 00 00 00 00
R 20AF 00 00 00 00
R 21AF 00 00 00 00
R 24AF 00 FF 00 00
I 0000 00 FF 00 00
W 10AF 40 00 00 00
W 11AF 41 00 00 00
W 12AF 42 00 00 00
W 13AF 43 00 00 00
W 20AF 05 00 00 00
W 24AF 7E 00 00 00
R 10AF 00 40 00 00
R 24AF 00 7E 00 00
P 0000 00 00 00 01
M 0123 00 02 01 00
M 4567 00 41 00 00
M 8ABC 00 42 00 00
M C000 00 43 00 00
W 21AF 02 00 00 00
M 1000 00 40 00 00
W 21AF 01 00 00 00
R 21AF 00 01 00 00
M 0000 00 03 01 00
F 3D2F 00 00 00 00
M 0000 00 01 01 00
R 20AF 00 85 00 00
F 4000 00 01 00 00
M 0000 00 03 01 00
W 00FE 15 00 00 00
P 0000 00 05 01 01
W 0FAF 02 00 00 00
P 0000 00 02 01 01
I 0000 00 7E 00 00

/* zbus_glue.f */
hw/zx_pkg.sv
hw/zsignals.sv
hw/zports.sv
hw/zpager.sv
hw/zint.sv
hw/zbus_glue.sv
tests/zbus_glue_assert.sv
tests/tb_zbus_glue.sv
